// File: build.f
+incdir+.
consumer_pkg.sv
channel_pair_merger.sv
packet_parser.sv
row_integrity_counter.sv
row_consumer_top.sv
tb_row_consumer.sv

// File: channel_pair_merger.sv
`timescale 1ns/100ps
// ========================================
// Pairs one beat from each input channel into a combined beat
// An early channel is stalled by dropping its tready
// rx_valid is high for one cycle per completed pair
// At most one TUSER-flagged beat is counted per cycle
// ========================================
module channel_pair_merger (
    input  logic                clk,
    input  logic                rst_n,
    input  consumer_pkg::lane_t ch0_tdata,
    input  logic                ch0_tvalid,
    input  logic                ch0_tlast,
    input  logic                ch0_tuser,
    input  consumer_pkg::lane_t ch1_tdata,
    input  logic                ch1_tvalid,
    input  logic                ch1_tlast,
    input  logic                ch1_tuser,
    input  logic                new_dataset,
    output logic                ch0_tready,
    output logic                ch1_tready,
    output consumer_pkg::lane_t rx0_data,
    output consumer_pkg::lane_t rx1_data,
    output logic [1:0]          rx_tlast,
    output logic                rx_valid,
    output logic [31:0]         bad_beats
);
    import consumer_pkg::*;

    lane_pair_t tready_q;   // Per-channel ready, bit 0 is channel 0
    lane_pair_t buf_valid;  // Per-channel buffer holds a beat
    lane_pair_t handshake;  // Per-channel transfer this cycle

    assign handshake  = {ch1_tvalid & tready_q[1], ch0_tvalid & tready_q[0]};
    assign ch0_tready = tready_q[0];
    assign ch1_tready = tready_q[1];
    assign rx_valid   = (buf_valid == BOTH);  // A full pair is ready for the parser

    // ========================================
    // Beat capture
    // ========================================
    always_ff @(posedge clk) begin
        if (handshake[0]) rx0_data <= ch0_tdata;
        if (handshake[1]) rx1_data <= ch1_tdata;
    end

    // Pairing control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tready_q  <= BOTH;     // Both channels may send after reset
            buf_valid <= NEITHER;
            rx_tlast  <= 2'b00;
        end else begin
            case (handshake)
                NEITHER: begin
                    // Buffers of channels still waiting for data are empty
                    buf_valid <= buf_valid & ~tready_q;
                    rx_tlast  <= rx_tlast & ~tready_q;
                end
                BOTH: begin
                    rx_tlast  <= {ch1_tlast, ch0_tlast};
                    buf_valid <= BOTH;  // Pair completes in one cycle
                end
                CH0: begin
                    rx_tlast[0] <= ch0_tlast;
                    // Stall channel 0 unless channel 1 is already waiting
                    tready_q    <= {1'b1, ~tready_q[1]};
                    buf_valid   <= {~tready_q[1], 1'b1};
                end
                CH1: begin
                    rx_tlast[1] <= ch1_tlast;
                    // Mirror of the channel 0 case
                    tready_q    <= {~tready_q[0], 1'b1};
                    buf_valid   <= {1'b1, ~tready_q[0]};
                end
            endcase
        end
    end

    // ========================================
    // Bad beat counter
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bad_beats <= '0;
        end else if (new_dataset) begin
            bad_beats <= '0;  // Fresh count for each dataset
        end else if ((handshake[0] & ch0_tuser) | (handshake[1] & ch1_tuser)) begin
            bad_beats <= bad_beats + 32'd1;  // Both flagged in one cycle still count once
        end
    end

endmodule

// File: consumer_consts.svh
// ========================================
// Size and pattern constants for the row consumer
// Defaults are small so that simulation stays short
// CONS_LANE_WIDTH must be a multiple of 32
// CONS_ROW_BYTES must divide evenly by the combined beat size
// CONS_UNDERFLOW_TIMEOUT must be less than CONS_SILENT_LIMIT
// ========================================
`ifndef CONSUMER_CONSTS_SVH
`define CONSUMER_CONSTS_SVH

// Bits carried by one channel per beat
`define CONS_LANE_WIDTH 128

// Bytes of row data in one row, header and footer excluded
`define CONS_ROW_BYTES 256

// Idle cycles after which the stream is considered silent
`define CONS_SILENT_LIMIT 200

// Idle cycles after which an underflow is reported
`define CONS_UNDERFLOW_TIMEOUT 50

// XOR masks for the data-integrity pattern (mask 0 is implicitly zero)
`define CONS_PAT_MASK_1 32'hFFFF_FFFF
`define CONS_PAT_MASK_2 32'hAAAA_AAAA
`define CONS_PAT_MASK_3 32'h5555_5555

`endif

// File: consumer_pkg.sv
// ========================================
// Shared types for the row consumer
// All widths follow the macros in the constants header
// ========================================
package consumer_pkg;

    `include "consumer_consts.svh"

    // One channel's data word
    typedef logic [`CONS_LANE_WIDTH-1:0] lane_t;

    // One bit per channel, bit 0 is channel 0
    typedef logic [1:0] lane_pair_t;
    localparam lane_pair_t NEITHER = 2'd0;
    localparam lane_pair_t CH0     = 2'd1;
    localparam lane_pair_t CH1     = 2'd2;
    localparam lane_pair_t BOTH    = 2'd3;

    // Packet type, carried in the low byte of the channel 1 word
    typedef enum logic [7:0] {
        ROW_DATA     = 8'd0,
        AXI_REQ      = 8'd1,
        TEST_PATTERN = 8'd3
    } pkt_type_t;

    typedef enum logic [1:0] {
        WAIT_PACKET,
        WAIT_ROW_DATA,
        WAIT_ROW_FOOTER,
        TOSS_PACKET
    } parser_state_t;

    typedef logic [95:0] axi_req_t;

    // Bytes in a combined beat (both channels together)
    localparam int BEAT_BYTES     = (2 * `CONS_LANE_WIDTH) / 8;
    localparam int ROW_DATA_BEATS = `CONS_ROW_BYTES / BEAT_BYTES;
    localparam int PAT_WORDS      = `CONS_LANE_WIDTH / 32;

endpackage

// File: packet_parser.sv
`timescale 1ns/100ps
// ========================================
// Decodes combined beats into row, request and test-pattern packets
// Packet type is the low byte of the channel 1 word
// Request beats do not reset the silence watchdog
// new_dataset, row_data_beat and row_done are combinational
// ========================================
`include "consumer_consts.svh"

module packet_parser (
    input  logic                   clk,
    input  logic                   rst_n,
    input  consumer_pkg::lane_t    rx1_data,
    input  logic [1:0]             rx_tlast,
    input  logic                   rx_valid,
    input  logic                   row_requestor_active,
    output logic                   new_dataset,
    output logic                   row_data_beat,
    output logic                   row_done,
    output logic                   row_complete,
    output consumer_pkg::axi_req_t axi_req_data,
    output logic                   axi_req_valid,
    output logic                   underflow,
    output logic                   job_complete
);
    import consumer_pkg::*;

    localparam int SIL_W = $clog2(`CONS_SILENT_LIMIT + 1);
    localparam int CNT_W = $clog2(ROW_DATA_BEATS + 1);

    localparam logic [SIL_W-1:0] SILENT_LIMIT      = SIL_W'(`CONS_SILENT_LIMIT);
    localparam logic [SIL_W-1:0] UNDERFLOW_TIMEOUT = SIL_W'(`CONS_UNDERFLOW_TIMEOUT);
    localparam logic [CNT_W-1:0] LAST_DATA_BEAT    = CNT_W'(ROW_DATA_BEATS);

    parser_state_t    state;
    logic [7:0]       pkt_type;
    logic [CNT_W-1:0] beat_cnt;       // Data beat number within the current row
    logic [SIL_W-1:0] silence_cnt;    // Idle cycles, saturating at the limit
    logic             rx_silent;
    logic             silence_clear;  // A consumed beat restarts the watchdog

    assign pkt_type = rx1_data[7:0];

    // ========================================
    // Silence watchdog
    // ========================================
    assign rx_silent   = (silence_cnt == SILENT_LIMIT) && !rx_valid;
    assign new_dataset = (silence_cnt == SILENT_LIMIT) && rx_valid;  // First beat after silence

    // Every beat except a request beat counts as stream activity
    assign silence_clear = rx_valid && !(state == WAIT_PACKET && pkt_type == AXI_REQ);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            silence_cnt <= SILENT_LIMIT;  // First beat after reset opens a dataset
        end else if (silence_clear) begin
            silence_cnt <= '0;
        end else if (!rx_valid && silence_cnt < SILENT_LIMIT) begin
            silence_cnt <= silence_cnt + 1'b1;
        end
    end

    // Beat classification for the integrity checker
    assign row_data_beat = rx_valid && (state == WAIT_ROW_DATA);
    assign row_done      = rx_valid && ((state == WAIT_ROW_FOOTER) ||
                                        (state == TOSS_PACKET && |rx_tlast));

    // ========================================
    // Packet FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= WAIT_PACKET;
            beat_cnt      <= '0;
            row_complete  <= 1'b0;
            axi_req_valid <= 1'b0;
            underflow     <= 1'b0;
            job_complete  <= 1'b0;
        end else begin
            row_complete  <= 1'b0;  // Strobes last one cycle
            axi_req_valid <= 1'b0;
            underflow     <= row_requestor_active && (silence_cnt == UNDERFLOW_TIMEOUT);
            job_complete  <= !row_requestor_active && !rx_valid &&
                             (silence_cnt == SILENT_LIMIT - 1'b1);

            if (rx_valid) begin
                case (state)
                    WAIT_PACKET: begin
                        case (pkt_type)
                            AXI_REQ:  axi_req_valid <= 1'b1;  // Single-beat request
                            ROW_DATA: begin
                                beat_cnt <= CNT_W'(1);
                                state    <= WAIT_ROW_DATA;
                            end
                            TEST_PATTERN: state <= TOSS_PACKET;
                            default:      state <= TOSS_PACKET;  // Unknown types are discarded too
                        endcase
                    end
                    WAIT_ROW_DATA: begin
                        if (beat_cnt == LAST_DATA_BEAT) state <= WAIT_ROW_FOOTER;
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    WAIT_ROW_FOOTER: begin
                        row_complete <= 1'b1;
                        state        <= WAIT_PACKET;
                    end
                    TOSS_PACKET: begin
                        if (|rx_tlast) state <= WAIT_PACKET;  // Either lane may close the packet
                    end
                endcase
            end

            if (rx_silent) state <= WAIT_PACKET;  // A silent stream always idles the FSM
        end
    end

    // Request payload, valid alongside axi_req_valid
    always_ff @(posedge clk) begin
        if (rx_valid && state == WAIT_PACKET && pkt_type == AXI_REQ) begin
            axi_req_data <= rx1_data[95:0];
        end
    end

endmodule

// File: row_consumer_top.sv
`timescale 1ns/100ps
// ========================================
// Top level of the two-lane row consumer
// The request strobe has no back-pressure
// Counters clear on the first beat after silence
// ========================================
module row_consumer_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  consumer_pkg::lane_t    ch0_tdata,
    input  logic                   ch0_tvalid,
    input  logic                   ch0_tlast,
    input  logic                   ch0_tuser,
    output logic                   ch0_tready,
    input  consumer_pkg::lane_t    ch1_tdata,
    input  logic                   ch1_tvalid,
    input  logic                   ch1_tlast,
    input  logic                   ch1_tuser,
    output logic                   ch1_tready,
    input  logic                   row_requestor_active,
    output consumer_pkg::axi_req_t axi_req_data,
    output logic                   axi_req_valid,
    output logic                   row_complete,
    output logic                   underflow,
    output logic                   job_complete,
    output logic [63:0]            rows_rcvd,
    output logic [31:0]            errors,
    output logic [31:0]            bad_beats
);
    import consumer_pkg::*;

    // Combined beat from the merger
    lane_t      rx0_data;
    lane_t      rx1_data;
    logic [1:0] rx_tlast;
    logic       rx_valid;

    // Parser classification
    logic new_dataset;
    logic row_data_beat;
    logic row_done;

    channel_pair_merger merger_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ch0_tdata   (ch0_tdata),
        .ch0_tvalid  (ch0_tvalid),
        .ch0_tlast   (ch0_tlast),
        .ch0_tuser   (ch0_tuser),
        .ch1_tdata   (ch1_tdata),
        .ch1_tvalid  (ch1_tvalid),
        .ch1_tlast   (ch1_tlast),
        .ch1_tuser   (ch1_tuser),
        .new_dataset (new_dataset),
        .ch0_tready  (ch0_tready),
        .ch1_tready  (ch1_tready),
        .rx0_data    (rx0_data),
        .rx1_data    (rx1_data),
        .rx_tlast    (rx_tlast),
        .rx_valid    (rx_valid),
        .bad_beats   (bad_beats)
    );

    packet_parser parser_inst (
        .clk                  (clk),
        .rst_n                (rst_n),
        .rx1_data             (rx1_data),
        .rx_tlast             (rx_tlast),
        .rx_valid             (rx_valid),
        .row_requestor_active (row_requestor_active),
        .new_dataset          (new_dataset),
        .row_data_beat        (row_data_beat),
        .row_done             (row_done),
        .row_complete         (row_complete),
        .axi_req_data         (axi_req_data),
        .axi_req_valid        (axi_req_valid),
        .underflow            (underflow),
        .job_complete         (job_complete)
    );

    row_integrity_counter checker_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx0_data      (rx0_data),
        .rx1_data      (rx1_data),
        .row_data_beat (row_data_beat),
        .row_done      (row_done),
        .new_dataset   (new_dataset),
        .rows_rcvd     (rows_rcvd),
        .errors        (errors)
    );

endmodule

// File: row_integrity_counter.sv
`timescale 1ns/100ps
// ========================================
// Counts received rows and malformed row-data beats
// Word k of each lane must equal word 0 XOR mask (k mod 4)
// A bad beat adds one however many words mismatch
// ========================================
`include "consumer_consts.svh"

module row_integrity_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  consumer_pkg::lane_t rx0_data,
    input  consumer_pkg::lane_t rx1_data,
    input  logic                row_data_beat,
    input  logic                row_done,
    input  logic                new_dataset,
    output logic [63:0]         rows_rcvd,
    output logic [31:0]         errors
);
    import consumer_pkg::*;

    localparam logic [31:0] PAT_MASK [4] = '{32'h0, `CONS_PAT_MASK_1,
                                             `CONS_PAT_MASK_2, `CONS_PAT_MASK_3};

    logic beat_bad;

    // True when every word of the lane follows the rotating XOR pattern
    function automatic logic lane_ok(input lane_t data);
        logic ok;
        ok = 1'b1;
        for (int k = 1; k < PAT_WORDS; k++) begin
            if (data[32*k +: 32] != (data[31:0] ^ PAT_MASK[k % 4])) ok = 1'b0;
        end
        return ok;
    endfunction

    assign beat_bad = !(lane_ok(rx0_data) && lane_ok(rx1_data));

    // ========================================
    // Counters
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n || new_dataset) begin
            rows_rcvd <= '0;
            errors    <= '0;
        end else begin
            if (row_done) rows_rcvd <= rows_rcvd + 64'd1;  // Footer or end of test pattern
            if (row_data_beat && beat_bad) errors <= errors + 32'd1;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f \
        --top-module tb_row_consumer -o tb_row_consumer; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_row_consumer)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Test OK$"; then
    exit 0
fi
exit 1

// File: tb_row_consumer.sv
`timescale 1ns/100ps
// ========================================
// Self-checking testbench for the row consumer
// Assumes the default sizes of the constants header
// (at least 3 words per lane, at most 8 data beats per row)
// Pulse outputs are counted at the falling edge
// ========================================
`include "consumer_consts.svh"

module tb_row_consumer;

    localparam int LANE_W     = `CONS_LANE_WIDTH;
    localparam int ROW_BEATS  = `CONS_ROW_BYTES / (LANE_W / 4);  // Combined beat is LANE_W/4 bytes
    localparam int WORDS      = LANE_W / 32;
    localparam int WAIT_LIMIT = 400;  // Cycles allowed for any single wait
    localparam int SEL_ROW    = 0;
    localparam int SEL_REQ    = 1;
    localparam int SEL_UNDER  = 2;
    localparam int SEL_JOB    = 3;

    logic              clk;
    logic              rst_n;
    logic [LANE_W-1:0] ch0_tdata;
    logic [LANE_W-1:0] ch1_tdata;
    logic              ch0_tvalid, ch0_tlast, ch0_tuser, ch0_tready;
    logic              ch1_tvalid, ch1_tlast, ch1_tuser, ch1_tready;
    logic              row_requestor_active;
    logic [95:0]       axi_req_data;
    logic              axi_req_valid, row_complete, underflow, job_complete;
    logic [63:0]       rows_rcvd;
    logic [31:0]       errors;
    logic [31:0]       bad_beats;

    int          seed = 32'hf2ad;
    int          fail_cnt = 0;
    int          timeout_cnt = 0;
    int          row_pulses = 0;
    int          req_pulses = 0;
    int          underflow_pulses = 0;
    int          job_pulses = 0;
    logic [95:0] last_req;
    longint      exp_rows = 0;  // Expected counter values
    int          exp_errors = 0;
    int          exp_bad = 0;

    row_consumer_top row_consumer_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // Pulse outputs are sampled at the falling edge where they are stable
    always @(negedge clk) begin
        if (rst_n) begin
            if (row_complete) row_pulses++;
            if (underflow) underflow_pulses++;
            if (job_complete) job_pulses++;
            if (axi_req_valid) begin
                req_pulses++;
                last_req = axi_req_data;  // Payload travels with the strobe
            end
        end
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (expected == actual) else begin
            $display("Error: %s expected 'h%0h actual 'h%0h", name, expected, actual);
            fail_cnt++;
        end
    endtask

    task automatic check_counters(input string name);
        check_value({name, " rows_rcvd"}, 128'(exp_rows), 128'(rows_rcvd));
        check_value({name, " errors"}, 128'(exp_errors), 128'(errors));
        check_value({name, " bad_beats"}, 128'(exp_bad), 128'(bad_beats));
    endtask

    function automatic int pulses_of(input int sel);
        case (sel)
            SEL_ROW:   return row_pulses;
            SEL_REQ:   return req_pulses;
            SEL_UNDER: return underflow_pulses;
            default:   return job_pulses;
        endcase
    endfunction

    task automatic wait_pulses(input int sel, input int target, input string what);
        int guard;
        guard = 0;
        while (pulses_of(sel) < target && guard < WAIT_LIMIT) begin
            @(posedge clk);  // Counters move at the falling edge only
            guard++;
        end
        if (pulses_of(sel) < target) begin
            $display("Timeout: no %s pulse arrived within %0d cycles", what, WAIT_LIMIT);
            timeout_cnt++;
        end
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // Word k is word 0 XOR mask (k mod 4) where mask 0 is zero
    function automatic logic [LANE_W-1:0] pattern_lane(input logic [31:0] word0);
        logic [31:0]       masks [4];
        logic [LANE_W-1:0] lane;
        masks = '{32'h0, `CONS_PAT_MASK_1, `CONS_PAT_MASK_2, `CONS_PAT_MASK_3};
        for (int k = 0; k < WORDS; k++) begin
            lane[32*k +: 32] = word0 ^ masks[k % 4];
        end
        return lane;
    endfunction

    function automatic logic [LANE_W-1:0] random_lane();
        logic [LANE_W-1:0] lane;
        for (int k = 0; k < WORDS; k++) begin
            lane[32*k +: 32] = $random(seed);
        end
        return lane;
    endfunction

    // Sends one beat per channel where a positive skew holds channel 1 back and a negative one
    // holds channel 0 back
    task automatic send_beat(input logic [LANE_W-1:0] d0, input logic [LANE_W-1:0] d1,
                             input logic [1:0] last, input logic [1:0] user, input int skew);
        int start0;
        int start1;
        int cyc;
        bit done0;
        bit done1;
        start0 = (skew < 0) ? -skew : 0;
        start1 = (skew > 0) ? skew : 0;
        cyc    = 0;
        done0  = 1'b0;
        done1  = 1'b0;
        while (!(done0 && done1) && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            if (cyc == 0) begin
                ch0_tdata <= d0;
                ch1_tdata <= d1;
                ch0_tlast <= last[0];
                ch1_tlast <= last[1];
                ch0_tuser <= user[0];
                ch1_tuser <= user[1];
            end
            ch0_tvalid <= !done0 && cyc >= start0;  // Drops on the edge that transfers
            ch1_tvalid <= !done1 && cyc >= start1;
            @(negedge clk);
            // An early channel stays stalled until its partner transfers
            if (done0 && !done1) check_value("ch0_tready stall", 128'(1'b0), 128'(ch0_tready));
            if (done1 && !done0) check_value("ch1_tready stall", 128'(1'b0), 128'(ch1_tready));
            // Valid and ready seen here hold through the next rising edge
            if (ch0_tvalid && ch0_tready) done0 = 1'b1;
            if (ch1_tvalid && ch1_tready) done1 = 1'b1;
            cyc++;
        end
        @(posedge clk);
        ch0_tvalid <= 1'b0;
        ch1_tvalid <= 1'b0;
        if (!(done0 && done1)) begin
            $display("Timeout: a channel never accepted its beat");
            timeout_cnt++;
        end
    endtask

    // Sends header, data beats and footer with one flipped word in each data beat whose
    // corrupt bit is set
    task automatic send_row(input string name, input logic [7:0] corrupt, input int skew);
        int                base;
        logic [LANE_W-1:0] d0;
        logic [LANE_W-1:0] d1;
        base = row_pulses;
        exp_errors += $countones(corrupt);
        d1 = random_lane();
        d1[7:0] = 8'h00;  // Row-data type
        send_beat(random_lane(), d1, 2'b00, 2'b00, skew);
        for (int i = 0; i < ROW_BEATS; i++) begin
            d0 = pattern_lane($random(seed));
            d1 = pattern_lane($random(seed));
            if (corrupt[0]) begin
                if (i % 2 == 0) d0[32 +: 32] = d0[32 +: 32] ^ 32'h0000_0100;
                else            d1[64 +: 32] = d1[64 +: 32] ^ 32'h0001_0000;
            end
            corrupt = corrupt >> 1;
            send_beat(d0, d1, 2'b00, 2'b00, skew);
        end
        send_beat(random_lane(), random_lane(), 2'b11, 2'b00, skew);  // Footer
        exp_rows++;
        wait_pulses(SEL_ROW, base + 1, "row_complete");
        settle(2);
        check_value({name, " row_complete pulses"}, 128'(base + 1), 128'(row_pulses));
        check_counters(name);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int                base_u;
        int                base_j;
        logic [31:0]       r;
        logic [LANE_W-1:0] word;
        ch0_tdata  <= '0;
        ch1_tdata  <= '0;
        {ch0_tvalid, ch0_tlast, ch0_tuser} <= 3'b000;
        {ch1_tvalid, ch1_tlast, ch1_tuser} <= 3'b000;
        row_requestor_active <= 1'b0;
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        send_row("row packet", 8'h00, 0);
        send_row("row packet", 8'h00, 0);
        r = $random(seed);
        send_row("corrupted row", r[7:0] | 8'h01, 0);  // At least one bad beat

        // A single-beat request carries its payload in the low 96 bits of channel 1
        base_u = req_pulses;
        word = random_lane();
        word[7:0] = 8'h01;
        send_beat(random_lane(), word, 2'b00, 2'b00, 0);
        wait_pulses(SEL_REQ, base_u + 1, "axi_req_valid");
        settle(3);
        check_value("axi_req pulses", 128'(base_u + 1), 128'(req_pulses));
        check_value("axi_req data", 128'(word[95:0]), 128'(last_req));
        check_counters("axi_req");

        for (int s = 1; s <= 3; s++) begin
            send_row("skew ch1 late", 8'h00, s);
            send_row("skew ch0 late", 8'h00, -s);
        end

        // Test-pattern packet with two flagged beats that tlast on channel 1 closes
        word = random_lane();
        word[7:0] = 8'h03;
        send_beat(random_lane(), word, 2'b00, 2'b00, -1);
        send_beat(random_lane(), random_lane(), 2'b00, 2'b01, 2);
        send_beat(random_lane(), random_lane(), 2'b00, 2'b10, -3);
        send_beat(random_lane(), random_lane(), 2'b10, 2'b00, 1);
        exp_rows++;
        exp_bad += 2;
        settle(3);
        check_counters("test pattern");

        // ========================================
        // Silence handling
        // ========================================
        @(posedge clk);
        row_requestor_active <= 1'b1;
        base_u = underflow_pulses;
        base_j = job_pulses;
        wait_pulses(SEL_UNDER, base_u + 1, "underflow");
        settle(`CONS_SILENT_LIMIT + 10);  // Let the stream go fully silent
        check_value("underflow pulses", 128'(base_u + 1), 128'(underflow_pulses));
        check_value("job_complete while requesting", 128'(base_j), 128'(job_pulses));

        exp_rows   = 0;  // Next row opens a new dataset
        exp_errors = 0;
        exp_bad    = 0;
        send_row("new dataset", 8'h24, 0);

        @(posedge clk);
        row_requestor_active <= 1'b0;
        base_u = underflow_pulses;
        base_j = job_pulses;
        wait_pulses(SEL_JOB, base_j + 1, "job_complete");
        settle(5);
        check_value("job_complete pulses", 128'(base_j + 1), 128'(job_pulses));
        check_value("underflow while idle", 128'(base_u), 128'(underflow_pulses));
        exp_rows   = 0;
        exp_errors = 0;
        exp_bad    = 0;
        send_row("after job", 8'h00, 1);

        $display("Checks failed: %0d, timeouts: %0d", fail_cnt, timeout_cnt);
        if (fail_cnt == 0 && timeout_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
